/* common/mhp_settings.svh */
`ifndef MHP_SETTINGS_SVH
`define MHP_SETTINGS_SVH

////////////////////////////////////////
// frame buffer
////////////////////////////////////////

`define MHP_RAM_DEPTH 256

// idle cycles that close a received frame
`define MHP_RX_GAP 63

// src, dst, size, type
`define MHP_HDR_LEN 7

////////////////////////////////////////
// transmit side
////////////////////////////////////////

// every reply goes out padded to this length
`define MHP_TX_LEN 16
`define MHP_TX_CREDITS 4
`define MHP_CREDIT_W 3

`endif

/* common/mhp_pkg.sv */
`default_nettype none

package mhp_pkg;

  // payload byte on the link and in the buffer
  typedef logic [7:0] byte_t;

  // frame buffer address
  typedef logic [7:0] ram_addr_t;

  // address, size and checksum fields
  typedef logic [15:0] word_t;

  // message types that get a reply
  typedef enum logic [7:0] {
    MSG_PING  = 8'h01,
    MSG_GRANT = 8'h04
  } msg_type_e;

endpackage

`default_nettype wire

/* rtl/frame_ram.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mhp_settings.svh"

module frame_ram (
  input  wire                     i_clk,
  // receiver
  input  wire mhp_pkg::ram_addr_t i_addr_rx,
  input  wire mhp_pkg::byte_t     i_wdata_rx,
  input  wire                     i_we_rx,
  // header parser
  input  wire mhp_pkg::ram_addr_t i_addr_hp,
  input  wire mhp_pkg::byte_t     i_wdata_hp,
  input  wire                     i_we_hp,
  // reply builder
  input  wire mhp_pkg::ram_addr_t i_addr_rb,
  input  wire mhp_pkg::byte_t     i_wdata_rb,
  input  wire                     i_we_rb,
  // checksum writer
  input  wire mhp_pkg::ram_addr_t i_addr_cs,
  input  wire mhp_pkg::byte_t     i_wdata_cs,
  input  wire                     i_we_cs,
  // transmitter
  input  wire mhp_pkg::ram_addr_t i_addr_tx,
  input  wire mhp_pkg::byte_t     i_wdata_tx,
  input  wire                     i_we_tx,
  output mhp_pkg::byte_t          o_rdata
);
  import mhp_pkg::*;

  byte_t     mem [`MHP_RAM_DEPTH];
  ram_addr_t addr;
  byte_t     wdata;
  logic      we;

  // idle clients hold zero, so OR selects the active one
  assign addr  = i_addr_rx | i_addr_hp | i_addr_rb | i_addr_cs | i_addr_tx;
  assign wdata = i_wdata_rx | i_wdata_hp | i_wdata_rb | i_wdata_cs | i_wdata_tx;
  assign we    = i_we_rx | i_we_hp | i_we_rb | i_we_cs | i_we_tx;

  always_ff @(posedge i_clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    o_rdata <= mem[addr];
  end

  // stages take turns on the buffer
  a_one_writer: assert property (@(posedge i_clk)
    $onehot0({i_we_rx, i_we_hp, i_we_rb, i_we_cs, i_we_tx}));

endmodule

`default_nettype wire

/* rx/frame_receiver.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mhp_settings.svh"

module frame_receiver (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire                     i_rx_ready,
  input  wire mhp_pkg::byte_t     i_rx_data,
  output logic                    o_rx_req,
  input  wire                     i_enable,
  output mhp_pkg::ram_addr_t      o_addr,
  output mhp_pkg::byte_t          o_wdata,
  output logic                    o_we,
  output logic                    o_start,
  output mhp_pkg::ram_addr_t      o_len
);
  import mhp_pkg::*;

  localparam int GAP_W = $clog2(`MHP_RX_GAP + 1);

  typedef enum logic [2:0] {RX_IDLE, RX_REQ, RX_DATA, RX_GAP, RX_BUSY} rx_state_e;

  rx_state_e        state;
  ram_addr_t        wr_ptr;
  logic [GAP_W-1:0] idle_cnt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= RX_IDLE;
      o_rx_req <= 1'b0;
      o_start  <= 1'b0;
      wr_ptr   <= '0;
      idle_cnt <= '0;
    end else begin
      o_rx_req <= 1'b0;
      o_start  <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (i_rx_ready) begin
            o_rx_req <= 1'b1;
            state    <= RX_REQ;
          end
        end
        RX_REQ: state <= RX_DATA;
        RX_DATA: begin
          wr_ptr   <= wr_ptr + 8'd1;
          idle_cnt <= '0;
          state    <= RX_GAP;
        end
        RX_GAP: begin
          if (i_rx_ready) begin
            o_rx_req <= 1'b1;
            state    <= RX_REQ;
          end else if (idle_cnt == GAP_W'(`MHP_RX_GAP - 1)) begin
            o_start <= 1'b1;
            state   <= RX_BUSY;
          end else begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
        // held until the chain reports the frame handled
        RX_BUSY: begin
          if (i_enable) begin
            wr_ptr <= '0;
            state  <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // byte is valid the cycle after the request
  assign o_we    = (state == RX_DATA);
  assign o_addr  = o_we ? wr_ptr : '0;
  assign o_wdata = o_we ? i_rx_data : '0;
  assign o_len   = wr_ptr;

endmodule

`default_nettype wire

/* proc/header_parser.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mhp_settings.svh"

module header_parser (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire                     i_start,
  input  wire mhp_pkg::ram_addr_t i_len,
  input  wire mhp_pkg::byte_t     i_rdata,
  output mhp_pkg::ram_addr_t      o_addr,
  output mhp_pkg::word_t          o_src,
  output mhp_pkg::word_t          o_dst,
  output mhp_pkg::byte_t          o_type,
  output logic                    o_hdr_ok,
  output logic                    o_done
);
  import mhp_pkg::*;

  typedef enum logic [1:0] {HP_IDLE, HP_ADDR, HP_WAIT, HP_LOAD} hp_state_e;

  hp_state_e  state;
  logic [2:0] idx;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= HP_IDLE;
      idx      <= '0;
      o_hdr_ok <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        HP_IDLE: begin
          if (i_start) begin
            idx      <= '0;
            o_hdr_ok <= (i_len >= ram_addr_t'(`MHP_HDR_LEN));
            state    <= HP_ADDR;
          end
        end
        HP_ADDR: state <= HP_WAIT;
        HP_WAIT: state <= HP_LOAD;
        HP_LOAD: begin
          if (idx == 3'(`MHP_HDR_LEN - 1)) begin
            o_done <= 1'b1;
            state  <= HP_IDLE;
          end else begin
            idx   <= idx + 3'd1;
            state <= HP_ADDR;
          end
        end
        default: state <= HP_IDLE;
      endcase
    end
  end

  // header fields, high byte first
  always_ff @(posedge i_clk) begin
    if (state == HP_LOAD) begin
      case (idx)
        3'd0: o_src[15:8] <= i_rdata;
        3'd1: o_src[7:0]  <= i_rdata;
        3'd2: o_dst[15:8] <= i_rdata;
        3'd3: o_dst[7:0]  <= i_rdata;
        3'd6: o_type      <= i_rdata;
        // size bytes 4 and 5 are not needed
        default: ;
      endcase
    end
  end

  assign o_addr = (state == HP_IDLE) ? '0 : ram_addr_t'(idx);

endmodule

`default_nettype wire

/* proc/reply_builder.sv */
`default_nettype none
`timescale 1ns/10ps

module reply_builder (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire                     i_start,
  input  wire mhp_pkg::word_t     i_src,
  input  wire mhp_pkg::word_t     i_dst,
  input  wire mhp_pkg::byte_t     i_type,
  input  wire                     i_hdr_ok,
  output mhp_pkg::ram_addr_t      o_addr,
  output mhp_pkg::byte_t          o_wdata,
  output logic                    o_we,
  output logic                    o_start_sum,
  output mhp_pkg::ram_addr_t      o_reply_len,
  output logic                    o_drop
);
  import mhp_pkg::*;

  // template plus two checksum bytes
  localparam ram_addr_t PING_LEN  = 8'd10;
  localparam ram_addr_t GRANT_LEN = 8'd11;

  typedef enum logic [1:0] {RB_IDLE, RB_TPL, RB_ADR} rb_state_e;

  rb_state_e state;
  ram_addr_t idx;
  logic      grant;

  function automatic byte_t tpl_byte(input logic is_grant, input ram_addr_t i);
    byte_t b;
    b = '0;
    if (is_grant) begin
      case (i)
        8'd5: b = 8'h02;
        8'd6: b = 8'h92;
        8'd7: b = 8'h01;
        8'd8: b = 8'h20;
        default: b = '0;
      endcase
    end else begin
      case (i)
        8'd5: b = 8'h01;
        8'd6: b = 8'h81;
        default: b = '0;
      endcase
    end
    return b;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= RB_IDLE;
      idx         <= '0;
      grant       <= 1'b0;
      o_reply_len <= '0;
      o_start_sum <= 1'b0;
      o_drop      <= 1'b0;
    end else begin
      o_start_sum <= 1'b0;
      o_drop      <= 1'b0;
      case (state)
        RB_IDLE: begin
          if (i_start) begin
            idx <= '0;
            if (!i_hdr_ok) begin
              o_drop <= 1'b1;
            end else begin
              case (msg_type_e'(i_type))
                MSG_PING: begin
                  grant       <= 1'b0;
                  o_reply_len <= PING_LEN;
                  state       <= RB_TPL;
                end
                MSG_GRANT: begin
                  grant       <= 1'b1;
                  o_reply_len <= GRANT_LEN;
                  state       <= RB_TPL;
                end
                default: o_drop <= 1'b1;
              endcase
            end
          end
        end
        RB_TPL: begin
          if (idx == o_reply_len - 8'd1) begin
            idx   <= '0;
            state <= RB_ADR;
          end else begin
            idx <= idx + 8'd1;
          end
        end
        // address overwrite of bytes 0 to 3
        RB_ADR: begin
          if (idx == 8'd3) begin
            o_start_sum <= 1'b1;
            state       <= RB_IDLE;
          end else begin
            idx <= idx + 8'd1;
          end
        end
        default: state <= RB_IDLE;
      endcase
    end
  end

  always_comb begin
    o_wdata = '0;
    if (state == RB_TPL) begin
      o_wdata = tpl_byte(grant, idx);
    end else if (state == RB_ADR) begin
      case (idx[1:0])
        2'd0: o_wdata = i_src[15:8];
        2'd1: o_wdata = i_src[7:0];
        2'd2: o_wdata = i_dst[15:8];
        default: o_wdata = i_dst[7:0];
      endcase
    end
  end

  assign o_we   = (state != RB_IDLE);
  assign o_addr = o_we ? idx : '0;

endmodule

`default_nettype wire

/* proc/checksum_writer.sv */
`default_nettype none
`timescale 1ns/10ps

module checksum_writer (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire                     i_start,
  input  wire mhp_pkg::ram_addr_t i_len,
  input  wire mhp_pkg::byte_t     i_rdata,
  output mhp_pkg::ram_addr_t      o_addr,
  output mhp_pkg::byte_t          o_wdata,
  output logic                    o_we,
  output logic                    o_done
);
  import mhp_pkg::*;

  typedef enum logic [2:0] {CS_IDLE, CS_RD, CS_ACC, CS_WR_HI, CS_WR_LO} cs_state_e;

  cs_state_e state;
  ram_addr_t idx;
  ram_addr_t len;
  word_t     sum;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= CS_IDLE;
      idx    <= '0;
      len    <= '0;
      sum    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        CS_IDLE: begin
          if (i_start) begin
            len   <= i_len;
            idx   <= '0;
            sum   <= '0;
            state <= CS_RD;
          end
        end
        CS_RD: state <= CS_ACC;
        // sum covers everything except the checksum bytes
        CS_ACC: begin
          sum <= sum + word_t'(i_rdata);
          if (idx == len - 8'd3) begin
            state <= CS_WR_HI;
          end else begin
            idx   <= idx + 8'd1;
            state <= CS_RD;
          end
        end
        CS_WR_HI: state <= CS_WR_LO;
        CS_WR_LO: begin
          o_done <= 1'b1;
          state  <= CS_IDLE;
        end
        default: state <= CS_IDLE;
      endcase
    end
  end

  always_comb begin
    o_addr  = '0;
    o_wdata = '0;
    o_we    = 1'b0;
    case (state)
      CS_RD, CS_ACC: o_addr = idx;
      CS_WR_HI: begin
        o_addr  = len - 8'd2;
        o_wdata = sum[15:8];
        o_we    = 1'b1;
      end
      CS_WR_LO: begin
        o_addr  = len - 8'd1;
        o_wdata = sum[7:0];
        o_we    = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* tx/frame_transmitter.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mhp_settings.svh"

module frame_transmitter (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire                     i_start,
  input  wire mhp_pkg::ram_addr_t i_len,
  input  wire mhp_pkg::byte_t     i_rdata,
  output mhp_pkg::ram_addr_t      o_addr,
  output mhp_pkg::byte_t          o_tx_data,
  output logic                    o_tx_valid,
  input  wire                     i_tx_credit,
  output logic                    o_done
);
  import mhp_pkg::*;

  localparam int CW = `MHP_CREDIT_W;

  typedef enum logic [1:0] {TX_IDLE, TX_ADDR, TX_SEND} tx_state_e;

  tx_state_e   state;
  ram_addr_t   idx;
  ram_addr_t   len;
  logic [CW-1:0] credit_cnt;
  logic        send;

  // byte leaves only with a credit in hand
  assign send = (state == TX_SEND) && (credit_cnt != '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= TX_IDLE;
      idx        <= '0;
      len        <= '0;
      o_tx_valid <= 1'b0;
      o_done     <= 1'b0;
    end else begin
      o_tx_valid <= send;
      o_done     <= 1'b0;
      case (state)
        TX_IDLE: begin
          if (i_start) begin
            len   <= i_len;
            idx   <= '0;
            state <= TX_ADDR;
          end
        end
        TX_ADDR: state <= TX_SEND;
        TX_SEND: begin
          if (send) begin
            if (idx == ram_addr_t'(`MHP_TX_LEN - 1)) begin
              o_done <= 1'b1;
              state  <= TX_IDLE;
            end else begin
              idx   <= idx + 8'd1;
              state <= TX_ADDR;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // zero padding past the reply
  always_ff @(posedge i_clk) begin
    if (send) begin
      o_tx_data <= (idx < len) ? i_rdata : '0;
    end
  end

  ////////////////////////////////////////
  // credits
  ////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      credit_cnt <= CW'(`MHP_TX_CREDITS);
    end else begin
      credit_cnt <= credit_cnt + CW'(i_tx_credit) - CW'(o_tx_valid);
    end
  end

  assign o_addr = (state == TX_IDLE) ? '0 : idx;

  a_credit_held: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tx_valid |-> (credit_cnt != '0));

endmodule

`default_nettype wire

/* rtl/mhp_top.sv */
`default_nettype none
`timescale 1ns/10ps

module mhp_top (
  input  wire                 i_clk,
  input  wire                 i_rst,
  input  wire                 i_rx_ready,
  input  wire mhp_pkg::byte_t i_rx_data,
  output logic                o_rx_req,
  output mhp_pkg::byte_t      o_tx_data,
  output logic                o_tx_valid,
  input  wire                 i_tx_credit,
  output logic                o_frame_done
);
  import mhp_pkg::*;

  byte_t     ram_rdata;
  ram_addr_t rx_addr, hp_addr, rb_addr, cs_addr, tx_addr;
  byte_t     rx_wdata, rb_wdata, cs_wdata;
  logic      rx_we, rb_we, cs_we;

  ////////////////////////////////////////
  // stage handshakes
  ////////////////////////////////////////

  logic      rx_start;
  ram_addr_t rx_len;
  word_t     hp_src, hp_dst;
  byte_t     hp_type;
  logic      hp_ok, hp_done;
  logic      rb_start_sum, rb_drop;
  ram_addr_t rb_len;
  logic      cs_done, tx_done;

  // a frame ends either dropped or sent
  assign o_frame_done = rb_drop | tx_done;

  frame_ram i_ram (
    .i_clk(i_clk),
    .i_addr_rx(rx_addr), .i_wdata_rx(rx_wdata), .i_we_rx(rx_we),
    .i_addr_hp(hp_addr), .i_wdata_hp('0),       .i_we_hp(1'b0),
    .i_addr_rb(rb_addr), .i_wdata_rb(rb_wdata), .i_we_rb(rb_we),
    .i_addr_cs(cs_addr), .i_wdata_cs(cs_wdata), .i_we_cs(cs_we),
    .i_addr_tx(tx_addr), .i_wdata_tx('0),       .i_we_tx(1'b0),
    .o_rdata(ram_rdata)
  );

  frame_receiver i_rx (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_rx_ready(i_rx_ready), .i_rx_data(i_rx_data), .o_rx_req(o_rx_req),
    .i_enable(o_frame_done),
    .o_addr(rx_addr), .o_wdata(rx_wdata), .o_we(rx_we),
    .o_start(rx_start), .o_len(rx_len)
  );

  header_parser i_hp (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_start(rx_start), .i_len(rx_len), .i_rdata(ram_rdata),
    .o_addr(hp_addr),
    .o_src(hp_src), .o_dst(hp_dst), .o_type(hp_type),
    .o_hdr_ok(hp_ok), .o_done(hp_done)
  );

  reply_builder i_rb (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_start(hp_done),
    .i_src(hp_src), .i_dst(hp_dst), .i_type(hp_type), .i_hdr_ok(hp_ok),
    .o_addr(rb_addr), .o_wdata(rb_wdata), .o_we(rb_we),
    .o_start_sum(rb_start_sum), .o_reply_len(rb_len), .o_drop(rb_drop)
  );

  checksum_writer i_cs (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_start(rb_start_sum), .i_len(rb_len), .i_rdata(ram_rdata),
    .o_addr(cs_addr), .o_wdata(cs_wdata), .o_we(cs_we),
    .o_done(cs_done)
  );

  frame_transmitter i_tx (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_start(cs_done), .i_len(rb_len), .i_rdata(ram_rdata),
    .o_addr(tx_addr),
    .o_tx_data(o_tx_data), .o_tx_valid(o_tx_valid), .i_tx_credit(i_tx_credit),
    .o_done(tx_done)
  );

endmodule

`default_nettype wire

/* bench/tb_mhp.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mhp_settings.svh"

module tb_mhp;
  import mhp_pkg::*;

  localparam int VEC_DEPTH = 1024;
  localparam int MAX_CASES = 16;
  localparam int MAX_RX    = 32;
  localparam int REPLY_BIT = 0;
  localparam int EARLY_BIT = 1;
  localparam int SLOW_BIT  = 2;

  logic  i_clk;
  logic  i_rst;
  logic  i_rx_ready;
  byte_t i_rx_data;
  logic  o_rx_req;
  byte_t o_tx_data;
  logic  o_tx_valid;
  logic  i_tx_credit;
  logic  o_frame_done;

  logic [15:0] vec [VEC_DEPTH];
  logic [15:0] flags [MAX_CASES];
  int          rx_len [MAX_CASES];
  byte_t       rx_bytes [MAX_CASES][MAX_RX];
  byte_t       exp_bytes [MAX_CASES][`MHP_TX_LEN];
  int          n_cases;

  byte_t tx_seen [$];
  int    errors;
  int    done_count;
  int    sent;
  int    returned;
  int    early_case;

  mhp_top i_dut (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_rx_ready(i_rx_ready), .i_rx_data(i_rx_data), .o_rx_req(o_rx_req),
    .o_tx_data(o_tx_data), .o_tx_valid(o_tx_valid), .i_tx_credit(i_tx_credit),
    .o_frame_done(o_frame_done)
  );

  always begin
    i_clk = 1'b0;
    #20;
    i_clk = 1'b1;
    #20;
  end

  ////////////////////////////////////////
  // vectors and stimulus
  ////////////////////////////////////////

  task automatic load_vectors();
    int pos;
    int i;
    $readmemh("bench/mhp_vectors.txt", vec);
    pos = 0;
    n_cases = 0;
    while (pos < VEC_DEPTH && !$isunknown(vec[pos]) && vec[pos] != 16'hffff &&
           n_cases < MAX_CASES) begin
      rx_len[n_cases] = int'(vec[pos]);
      flags[n_cases]  = vec[pos + 1];
      pos = pos + 2;
      for (i = 0; i < rx_len[n_cases] && i < MAX_RX; i++) begin
        rx_bytes[n_cases][i] = vec[pos + i][7:0];
      end
      pos = pos + rx_len[n_cases];
      if (flags[n_cases][REPLY_BIT]) begin
        for (i = 0; i < `MHP_TX_LEN; i++) begin
          exp_bytes[n_cases][i] = vec[pos + i][7:0];
        end
        pos = pos + `MHP_TX_LEN;
      end
      n_cases++;
    end
  endtask

  // one byte per request with random idle stretches well under the gap
  task automatic send_frame(input int k);
    int i;
    int gap;
    for (i = 0; i < rx_len[k]; i++) begin
      i_rx_ready = 1'b1;
      @(negedge i_clk);
      while (!o_rx_req) @(negedge i_clk);
      i_rx_data = rx_bytes[k][i];
      gap = int'($urandom % 20);
      if (gap > 0) begin
        i_rx_ready = 1'b0;
        repeat (gap) @(negedge i_clk);
      end
    end
    i_rx_ready = 1'b0;
  endtask

  ////////////////////////////////////////
  // output checks
  ////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] got);
    errors++;
    $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic check_frame(input int k);
    int    i;
    int    rlen;
    word_t sum;
    word_t got_sum;
    if (k >= n_cases) begin
      errors++;
      $display("t=%0t o_frame_done pulsed with no frame pending", $time);
    end else if (!flags[k][REPLY_BIT]) begin
      if (tx_seen.size() != 0) begin
        errors++;
        $display("t=%0t frame %0d sent %0d bytes but needs no reply",
                 $time, k, tx_seen.size());
      end
    end else if (tx_seen.size() != `MHP_TX_LEN) begin
      errors++;
      $display("t=%0t frame %0d sent %0d bytes instead of %0d",
               $time, k, tx_seen.size(), `MHP_TX_LEN);
    end else begin
      for (i = 0; i < `MHP_TX_LEN; i++) begin
        if (tx_seen[i] !== exp_bytes[k][i]) begin
          report_mismatch($sformatf("o_tx_data[%0d]", i), 16'(exp_bytes[k][i]),
                          16'(tx_seen[i]));
        end
      end
      // reply addresses come straight from the received header
      for (i = 0; i < 4; i++) begin
        if (tx_seen[i] !== rx_bytes[k][i]) begin
          report_mismatch($sformatf("reply address byte %0d", i), 16'(rx_bytes[k][i]),
                          16'(tx_seen[i]));
        end
      end
      rlen = (rx_bytes[k][6] == MSG_GRANT) ? 11 : 10;
      sum = '0;
      for (i = 0; i < rlen - 2; i++) begin
        sum = sum + word_t'(exp_bytes[k][i]);
      end
      got_sum = {tx_seen[rlen - 2], tx_seen[rlen - 1]};
      if (got_sum !== sum) begin
        report_mismatch("checksum", sum, got_sum);
      end
    end
    tx_seen.delete();
  endtask

  initial begin : monitor
    errors = 0;
    done_count = 0;
    sent = 0;
    forever begin
      @(negedge i_clk);
      if (i_rst) begin
        if (o_rx_req !== 1'b0) report_mismatch("o_rx_req", 16'h0, {15'h0, o_rx_req});
        if (o_tx_valid !== 1'b0) report_mismatch("o_tx_valid", 16'h0, {15'h0, o_tx_valid});
        if (o_frame_done !== 1'b0) report_mismatch("o_frame_done", 16'h0, {15'h0, o_frame_done});
      end else begin
        if (o_rx_req && early_case >= 0 && done_count == early_case) begin
          errors++;
          $display("t=%0t o_rx_req pulsed before frame %0d was done", $time, early_case);
        end
        if (o_tx_valid) begin
          tx_seen.push_back(o_tx_data);
          sent++;
        end
        if (sent - returned > `MHP_TX_CREDITS) begin
          errors++;
          $display("t=%0t %0d bytes sent against %0d credits returned", $time, sent, returned);
        end
        if (o_frame_done) begin
          check_frame(done_count);
          done_count++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // credit returns
  ////////////////////////////////////////

  initial begin : credit_return
    int   delay;
    logic slow;
    i_tx_credit = 1'b0;
    returned = 0;
    forever begin
      @(negedge i_clk);
      if (sent > returned) begin
        slow = (done_count < n_cases) && flags[done_count][SLOW_BIT];
        delay = slow ? 8 + int'($urandom % 24) : int'($urandom % 3);
        repeat (delay) @(negedge i_clk);
        i_tx_credit = 1'b1;
        @(negedge i_clk);
        i_tx_credit = 1'b0;
        returned++;
      end
    end
  end

  initial begin : watchdog
    wait (n_cases > 0);
    repeat (n_cases * 3000) @(posedge i_clk);
    $display("timeout after %0d cycles, %0d of %0d frames handled",
             n_cases * 3000, done_count, n_cases);
    $display("Errors found");
    $finish;
  end

  initial begin : main
    int k;
    int fails;
    i_rst = 1'b1;
    i_rx_ready = 1'b0;
    i_rx_data = '0;
    early_case = -1;
    void'($urandom(32'heedf));
    load_vectors();
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    for (k = 0; k < n_cases; k++) begin
      send_frame(k);
      if (flags[k][EARLY_BIT]) begin
        // frame has closed so the next source raises ready while this one is handled
        repeat (`MHP_RX_GAP + 4) @(negedge i_clk);
        early_case = k;
      end else begin
        while (done_count <= k) @(negedge i_clk);
      end
    end
    while (done_count < n_cases) @(negedge i_clk);
    repeat (200) @(negedge i_clk);
    fails = errors;
    if (n_cases == 0) begin
      fails++;
      $display("no test cases read from the vector file");
    end
    if (tx_seen.size() != 0) begin
      fails++;
      $display("%0d bytes sent after the last frame was done", tx_seen.size());
    end
    $display("frames %0d of %0d, errors %0d", done_count, n_cases, fails);
    if (fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/mhp_pkg.sv
rtl/frame_ram.sv
rx/frame_receiver.sv
proc/header_parser.sv
proc/reply_builder.sv
proc/checksum_writer.sv
tx/frame_transmitter.sv
rtl/mhp_top.sv
bench/tb_mhp.sv

/* run.sh */
#!/bin/sh
# build and run the mhp testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f list.f --top-module tb_mhp -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_mhp)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1

/* bench/mhp_vectors.txt */
// per case: rx byte count, flags (bit0 reply expected, bit1 next frame sent early,
// bit2 slow credit returns), received bytes, then 16 expected tx bytes if bit0 is set

// ping with one payload byte
0008 0001
12 34 56 78 00 08 01 aa
12 34 56 78 00 01 81 00 01 96 00 00 00 00 00 00

// address grant
0007 0001
a1 b2 c3 d4 00 07 04
a1 b2 c3 d4 00 02 92 01 20 03 9f 00 00 00 00 00

// unknown type, no reply
0007 0000
01 02 03 04 00 07 03

// short frame, no reply
0005 0000
01 01 02 02 00

// ping under withheld credits
0007 0005
ff ee 10 20 00 07 01
ff ee 10 20 00 01 81 00 02 9f 00 00 00 00 00 00

// back-to-back chain of three frames
0008 0003
00 05 00 09 00 08 04 5a
00 05 00 09 00 02 92 01 20 00 c3 00 00 00 00 00
0007 0003
80 00 7f ff 00 07 01
80 00 7f ff 00 01 81 00 02 80 00 00 00 00 00 00
0007 0000
00 10 00 20 00 07 02

ffff
